// File: logic/rot_bus_pkg.sv
package rot_bus_pkg;

	typedef logic [31:0] data_t; // bus data word
	typedef logic [7:0]  addr_t; // byte address

	// wishbone classic request, master to slave
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
		data_t dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		data_t dat;
	} wb_rsp_t;

	localparam addr_t ADR_OP     = 8'h00;
	localparam addr_t ADR_STATUS = 8'h04;
	localparam addr_t ADR_UNLOCK = 8'h08;
	localparam addr_t ADR_KEY0   = 8'h10; // key words at 0x10..0x1c
	localparam addr_t ADR_RNG0   = 8'h20; // lane word n at 0x20 + 4n

	localparam int KEY_WORDS = 4; // 128-bit aes key

endpackage

// File: logic/rot_cmd_pkg.sv
package rot_cmd_pkg;

	typedef logic [7:0] opcode_t; // taken from dat[7:0]

	localparam opcode_t OP_NOP          = 8'd0;
	localparam opcode_t OP_STATUS_CLEAR = 8'd1;
	localparam opcode_t OP_KEY_CLEAR    = 8'd2;
	localparam opcode_t OP_RNG_GEN      = 8'd3;
	localparam opcode_t OP_RNG_CLEAR    = 8'd4;
	localparam opcode_t OP_LOCK         = 8'd5;

	localparam int ST_UNLOCKED  = 0;
	localparam int ST_RNG_VALID = 2;
	localparam int ST_GEN_CNT   = 26; // lsb of the generation count
	localparam int ST_GEN_W     = 3;
	localparam int ST_RNG_DIRTY = 29;

	typedef enum logic [1:0] {LOCKED, CHECK, READY} ctrl_state_e;

	typedef struct packed {
		logic step;
		logic clear;
	} lane_cmd_t;

	typedef enum logic [1:0] {NONE, STATUS, KEY, RNG} rd_sel_e;

	typedef struct packed {
		logic               key_we;
		logic               key_clr;
		logic [2:0]         idx; // key word or lane index
		rd_sel_e            rd_sel;
		rot_bus_pkg::data_t wdat;
	} reg_req_t;

endpackage

// File: logic/rot_ctrl.sv
`timescale 1ns/1ps

module rot_ctrl #(
	parameter rot_bus_pkg::data_t UNLOCK_WORD = 32'hF0F0AAAA,
	parameter int unsigned        MAX_GEN     = 6
)(
	input  logic                   clk,
	input  logic                   rst_n,
	input  rot_bus_pkg::wb_req_t   wb_i,
	output logic                   ack_o,
	output rot_cmd_pkg::lane_cmd_t lane_cmd_o,
	output rot_cmd_pkg::reg_req_t  reg_req_o,
	output rot_bus_pkg::data_t     status_o
);

	localparam rot_bus_pkg::addr_t KEY_SPAN = rot_bus_pkg::addr_t'(4 * rot_bus_pkg::KEY_WORDS);
	localparam rot_bus_pkg::addr_t RNG_SPAN = 8'h20; // room for eight lanes

	rot_cmd_pkg::ctrl_state_e state_q;
	logic                     ack_q;
	logic [4:0]               bit_cnt_q;
	logic                     mismatch_q;
	rot_bus_pkg::data_t       status_q;
	rot_cmd_pkg::lane_cmd_t   lane_cmd_q;

	logic                 hit;
	logic                 aligned;
	logic                 is_op;
	logic                 is_status;
	logic                 is_unlock;
	logic                 is_key;
	logic                 is_rng;
	rot_bus_pkg::addr_t   key_off;
	rot_bus_pkg::addr_t   rng_off;
	logic [2:0]           word_idx;
	rot_cmd_pkg::opcode_t opcode;
	logic                 bit_bad;
	logic [2:0]           gen_cnt;

	// one decode per access
	assign hit       = wb_i.cyc && wb_i.stb && !ack_q;
	assign aligned   = wb_i.adr[1:0] == 2'b00;
	assign key_off   = wb_i.adr - rot_bus_pkg::ADR_KEY0;
	assign rng_off   = wb_i.adr - rot_bus_pkg::ADR_RNG0;
	assign is_op     = wb_i.adr == rot_bus_pkg::ADR_OP;
	assign is_status = wb_i.adr == rot_bus_pkg::ADR_STATUS;
	assign is_unlock = wb_i.adr == rot_bus_pkg::ADR_UNLOCK;
	assign is_key    = aligned && wb_i.adr >= rot_bus_pkg::ADR_KEY0 && key_off < KEY_SPAN;
	assign is_rng    = aligned && wb_i.adr >= rot_bus_pkg::ADR_RNG0 && rng_off < RNG_SPAN;
	assign word_idx  = is_rng ? rng_off[4:2] : key_off[4:2];
	assign opcode    = wb_i.dat[7:0];

	assign bit_bad = wb_i.dat[bit_cnt_q] ^ UNLOCK_WORD[bit_cnt_q]; // msb first
	assign gen_cnt = status_q[rot_cmd_pkg::ST_GEN_CNT +: rot_cmd_pkg::ST_GEN_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= rot_cmd_pkg::LOCKED;
			ack_q      <= 1'b0;
			bit_cnt_q  <= 5'd0;
			mismatch_q <= 1'b0;
			status_q   <= '0;
			lane_cmd_q <= '0;
		end else begin
			ack_q      <= 1'b0;
			lane_cmd_q <= '0;
			case (state_q)
				rot_cmd_pkg::LOCKED: begin
					if (hit) begin
						if (wb_i.we && is_unlock) begin
							state_q    <= rot_cmd_pkg::CHECK; // stall, no ack yet
							bit_cnt_q  <= 5'd31;
							mismatch_q <= 1'b0;
						end else begin
							ack_q <= 1'b1;
						end
					end
				end
				rot_cmd_pkg::CHECK: begin
					if (!wb_i.cyc) begin
						state_q <= rot_cmd_pkg::LOCKED; // master gave up
					end else if (bit_cnt_q == 5'd0) begin
						ack_q <= 1'b1;
						if (mismatch_q || bit_bad) begin
							state_q <= rot_cmd_pkg::LOCKED;
						end else begin
							state_q                           <= rot_cmd_pkg::READY;
							status_q[rot_cmd_pkg::ST_UNLOCKED] <= 1'b1;
						end
					end else begin
						bit_cnt_q  <= bit_cnt_q - 5'd1;
						mismatch_q <= mismatch_q | bit_bad;
					end
				end
				rot_cmd_pkg::READY: begin
					if (hit) begin
						ack_q <= 1'b1;
						if (wb_i.we && is_op) begin
							case (opcode)
								rot_cmd_pkg::OP_STATUS_CLEAR: begin
									status_q[rot_cmd_pkg::ST_GEN_CNT +: rot_cmd_pkg::ST_GEN_W] <= '0;
									status_q[rot_cmd_pkg::ST_RNG_DIRTY]                       <= 1'b0;
									status_q[rot_cmd_pkg::ST_RNG_VALID]                       <= 1'b0;
								end
								rot_cmd_pkg::OP_RNG_GEN: begin
									if (32'(gen_cnt) < MAX_GEN) begin
										lane_cmd_q.step <= 1'b1;
										status_q[rot_cmd_pkg::ST_GEN_CNT +: rot_cmd_pkg::ST_GEN_W] <=
											gen_cnt + 3'd1;
										status_q[rot_cmd_pkg::ST_RNG_VALID] <= 1'b1;
										status_q[rot_cmd_pkg::ST_RNG_DIRTY] <= 1'b1;
									end
								end
								rot_cmd_pkg::OP_RNG_CLEAR: begin
									lane_cmd_q.clear                    <= 1'b1;
									status_q[rot_cmd_pkg::ST_RNG_VALID] <= 1'b0;
								end
								rot_cmd_pkg::OP_LOCK: begin
									state_q                           <= rot_cmd_pkg::LOCKED;
									status_q[rot_cmd_pkg::ST_UNLOCKED] <= 1'b0;
								end
								default: ; // nop, key clear goes straight to the regfile
							endcase
						end
					end
				end
				default: state_q <= rot_cmd_pkg::LOCKED;
			endcase
		end
	end

	// regfile request for the access being acked this edge
	always_comb begin
		reg_req_o      = '0;
		reg_req_o.idx  = word_idx;
		reg_req_o.wdat = wb_i.dat;
		if (hit && state_q == rot_cmd_pkg::READY) begin
			if (wb_i.we) begin
				reg_req_o.key_we  = is_key;
				reg_req_o.key_clr = is_op && opcode == rot_cmd_pkg::OP_KEY_CLEAR;
			end else if (is_status) begin
				reg_req_o.rd_sel = rot_cmd_pkg::STATUS;
			end else if (is_key) begin
				reg_req_o.rd_sel = rot_cmd_pkg::KEY;
			end else if (is_rng) begin
				reg_req_o.rd_sel = rot_cmd_pkg::RNG;
			end
		end
	end

	assign ack_o      = ack_q;
	assign lane_cmd_o = lane_cmd_q;
	assign status_o   = status_q;

endmodule

// File: logic/rot_prng_lane.sv
`timescale 1ns/1ps

module rot_prng_lane #(
	parameter rot_bus_pkg::data_t SEED = 32'h1F2E0001
)(
	input  logic                   clk,
	input  logic                   rst_n,
	input  rot_cmd_pkg::lane_cmd_t cmd_i,
	output rot_bus_pkg::data_t     word_o
);

	rot_bus_pkg::data_t lfsr_q;
	rot_bus_pkg::data_t lfsr_nxt;
	rot_bus_pkg::data_t word_q;

	// taps 32 22 2 1, shift left
	assign lfsr_nxt = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr_q <= SEED;
			word_q <= '0;
		end else if (cmd_i.step) begin
			lfsr_q <= lfsr_nxt;
			word_q <= lfsr_nxt; // capture the new value
		end else if (cmd_i.clear) begin
			word_q <= '0; // lfsr keeps running state
		end
	end

	assign word_o = word_q;

endmodule

// File: logic/rot_regfile.sv
`timescale 1ns/1ps

module rot_regfile #(
	parameter int LANES = 4
)(
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  rot_cmd_pkg::reg_req_t                req_i,
	input  rot_bus_pkg::data_t                   status_i,
	input  rot_bus_pkg::data_t [LANES-1:0]       lane_words_i,
	output rot_bus_pkg::data_t                   dat_o
);

	localparam int LANE_SLOTS = 8; // reach of the 3-bit word index
	localparam int KEY_IW     = $clog2(rot_bus_pkg::KEY_WORDS);

	rot_bus_pkg::data_t key_q [rot_bus_pkg::KEY_WORDS];
	rot_bus_pkg::data_t lane_ext [LANE_SLOTS];
	rot_bus_pkg::data_t rd_val;
	rot_bus_pkg::data_t dat_q;
	logic [KEY_IW-1:0]  key_idx;

	assign key_idx = req_i.idx[KEY_IW-1:0];

	always_ff @(posedge clk) begin
		if (req_i.key_clr) begin
			for (int i = 0; i < rot_bus_pkg::KEY_WORDS; i++) begin
				key_q[i] <= '0;
			end
		end else if (req_i.key_we) begin
			key_q[key_idx] <= req_i.wdat;
		end
	end

	// slots past LANES stay zero
	always_comb begin
		lane_ext = '{default: '0};
		for (int i = 0; i < LANES; i++) begin
			lane_ext[i] = lane_words_i[i];
		end
	end

	always_comb begin
		case (req_i.rd_sel)
			rot_cmd_pkg::STATUS: rd_val = status_i;
			rot_cmd_pkg::KEY:    rd_val = key_q[key_idx];
			rot_cmd_pkg::RNG:    rd_val = lane_ext[req_i.idx];
			default:             rd_val = '0; // locked, write or unmapped
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dat_q <= '0;
		end else begin
			dat_q <= rd_val;
		end
	end

	assign dat_o = dat_q;

endmodule

// File: logic/rot_top.sv
`timescale 1ns/1ps

module rot_top #(
	parameter int                 LANES       = 4,
	parameter rot_bus_pkg::data_t UNLOCK_WORD = 32'hF0F0AAAA,
	parameter int unsigned        MAX_GEN     = 6
)(
	input  logic                 clk,
	input  logic                 rst_n,
	input  rot_bus_pkg::wb_req_t wb_i,
	output rot_bus_pkg::wb_rsp_t wb_o
);

	logic                                ack;
	rot_cmd_pkg::lane_cmd_t              lane_cmd; // shared by all lanes
	rot_cmd_pkg::reg_req_t               reg_req;
	rot_bus_pkg::data_t                  status;
	rot_bus_pkg::data_t [LANES-1:0]      lane_words;
	rot_bus_pkg::data_t                  rd_dat;

	rot_ctrl #(
		.UNLOCK_WORD(UNLOCK_WORD),
		.MAX_GEN    (MAX_GEN)
	) ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_i      (wb_i),
		.ack_o     (ack),
		.lane_cmd_o(lane_cmd),
		.reg_req_o (reg_req),
		.status_o  (status)
	);

	for (genvar l = 0; l < LANES; l++) begin : g_lane
		rot_prng_lane #(
			.SEED(32'h1F2E0000 + 32'(l) + 32'd1)
		) lane_i (
			.clk   (clk),
			.rst_n (rst_n),
			.cmd_i (lane_cmd),
			.word_o(lane_words[l])
		);
	end

	rot_regfile #(
		.LANES(LANES)
	) regfile_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (reg_req),
		.status_i    (status),
		.lane_words_i(lane_words),
		.dat_o       (rd_dat)
	);

	assign wb_o.ack = ack;
	assign wb_o.dat = rd_dat;

endmodule

// File: run.sh
#!/bin/sh
# build and run the rot testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rot_tb -f verilog.f -o Vrot_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vrot_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "PASS: all tests" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// File: verif/rot_golden.txt
# kind adr data tag, hex fields; W carries write data, R the expected read data
# lane n reads the lfsr seeded with 1f2e0000 + n + 1
W 10 DEADBEEF locked_key_wr
R 04 00000000 locked_status
R 10 00000000 locked_key0
R 20 00000000 locked_rng0
W 08 12345678 bad_unlock
R 04 00000000 bad_unlock_status
W 08 F0F0AAAA good_unlock
R 04 00000001 unlocked_status
W 08 F0F0AAAA unlock_again
W 10 01234567 key0_wr
W 14 89ABCDEF key1_wr
W 18 DEADBEEF key2_wr
W 1C CAFEF00D key3_wr
R 10 01234567 key0_rd
R 14 89ABCDEF key1_rd
R 18 DEADBEEF key2_rd
R 1C CAFEF00D key3_rd
R 40 00000000 unmapped_rd
W 00 00000002 key_clear
R 10 00000000 key0_cleared
R 14 00000000 key1_cleared
R 18 00000000 key2_cleared
R 1C 00000000 key3_cleared
W 00 00000003 gen_1
R 20 3E5C0002 lane0_step1
R 24 3E5C0004 lane1_step1
R 28 3E5C0007 lane2_step1
R 2C 3E5C0009 lane3_step1
R 04 24000005 status_gen1
W 00 00000003 gen_2
R 20 7CB80005 lane0_step2
R 24 7CB80008 lane1_step2
R 28 7CB8000E lane2_step2
R 2C 7CB80013 lane3_step2
W 00 00000004 rng_clear
R 20 00000000 lane0_cleared
R 04 28000001 status_rng_clear
W 00 00000001 status_clear_a
W 00 00000003 burst_gen_1
W 00 00000003 burst_gen_2
W 00 00000003 burst_gen_3
W 00 00000003 burst_gen_4
W 00 00000003 burst_gen_5
W 00 00000003 burst_gen_6
W 00 00000003 burst_gen_7
R 04 38000005 status_gen_limit
R 20 2E00015F lane0_step8
R 2C 2E0004E9 lane3_step8
W 00 00000001 status_clear_b
R 04 00000001 status_cleared
W 00 00000003 gen_after_clear
R 20 5C0002BE lane0_step9
W 10 13579BDF key0_before_lock
W 00 00000005 lock
R 04 00000000 locked_status_again
R 10 00000000 locked_key0_again
W 08 F0F0AAAA relock_unlock
R 04 24000005 status_after_relock
R 10 13579BDF key0_after_relock

// File: verif/rot_tb.sv
`timescale 1ns/1ps

module rot_tb;

	localparam rot_bus_pkg::data_t UNLOCK_WORD = 32'hF0F0AAAA;
	localparam int                 UNLOCK_LAT  = 33; // one cycle per key bit plus the ack

	logic                 clk;
	logic                 rst_n;
	rot_bus_pkg::wb_req_t wb_req;
	rot_bus_pkg::wb_rsp_t wb_rsp;

	logic [7:0]         kinds [$]; // 'W' or 'R'
	rot_bus_pkg::addr_t adrs [$];
	rot_bus_pkg::data_t dats [$];  // write data or expected read data
	logic [8*24-1:0]    tags [$];

	int          data_errs;
	int          lat_errs;
	int          file_errs;
	int          cycles;
	int          limit;
	logic        locked;   // expected lock state of the block
	logic [31:0] rnd;

	rot_top rot_top_i (
		.clk  (clk),
		.rst_n(rst_n),
		.wb_i (wb_req),
		.wb_o (wb_rsp)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// taps 32 31 29 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[30] ^ s[28] ^ s[0]};
	endfunction

	function automatic int next_gap();
		int gap;
		gap = 0;
		for (int b = 0; b < 3; b++) begin
			rnd = lfsr_step(rnd);
			gap = (gap << 1) | int'(rnd[0]);
		end
		return gap;
	endfunction

	task automatic load_golden();
		int              fd;
		int              n;
		string           line;
		logic [7:0]      kind;
		logic [31:0]     adr_w;
		logic [31:0]     dat_w;
		logic [8*24-1:0] tag;
		fd = $fopen("verif/rot_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file verif/rot_golden.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %h %h %s", kind, adr_w, dat_w, tag);
				if (n == 4) begin
					kinds.push_back(kind);
					adrs.push_back(adr_w[7:0]);
					dats.push_back(dat_w);
					tags.push_back(tag);
				end
			end
		end
		$fclose(fd);
	endtask

	// drives one transfer on the current rising edge and returns on the edge that samples ack
	task automatic run_txn(input int i);
		int   lat;
		int   exp_lat;
		logic is_wr;
		is_wr   = kinds[i] == "W";
		exp_lat = (is_wr && adrs[i] == rot_bus_pkg::ADR_UNLOCK && locked) ? UNLOCK_LAT : 1;
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= is_wr;
		wb_req.adr <= adrs[i];
		wb_req.dat <= is_wr ? dats[i] : '0;
		@(posedge clk); // first edge that samples the strobe
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!wb_rsp.ack);
		if (lat != exp_lat) begin
			$display("latency wrong on %0s at %0t: expected ack after %0d cycles, got %0d",
				tags[i], $time, exp_lat, lat);
			lat_errs++;
		end
		if (!is_wr && wb_rsp.dat !== dats[i]) begin
			$display("[ERROR] %0t wb_o.dat (%0s): expected %08h, actual %08h",
				$time, tags[i], dats[i], wb_rsp.dat);
			data_errs++;
		end
		if (is_wr && adrs[i] == rot_bus_pkg::ADR_UNLOCK && locked && dats[i] == UNLOCK_WORD) begin
			locked = 1'b0;
		end else if (is_wr && adrs[i] == rot_bus_pkg::ADR_OP && !locked &&
			dats[i][7:0] == rot_cmd_pkg::OP_LOCK) begin
			locked = 1'b1;
		end
		@(posedge clk); // master sees ack here
	endtask

	initial begin
		int total;
		int gap;
		rst_n     <= 1'b0;
		wb_req    <= '0;
		rnd       = 32'h17f0;
		locked    = 1'b1;
		data_errs = 0;
		lat_errs  = 0;
		file_errs = 0;
		load_golden();
		limit = kinds.size() * 41 + 100;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		if (kinds.size() == 0) begin
			$display("no transactions found in the golden file");
			file_errs++;
		end
		for (int i = 0; i < kinds.size(); i++) begin
			run_txn(i);
			gap = next_gap();
			if (gap > 0) begin
				wb_req.cyc <= 1'b0;
				wb_req.stb <= 1'b0;
				repeat (gap) @(posedge clk);
			end
		end
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
		repeat (4) @(posedge clk);
		total = data_errs + lat_errs + file_errs + rot_top_i.wb_assert_i.assert_errs;
		$display("errors: data %0d, latency %0d, file %0d, assertion %0d", data_errs, lat_errs,
			file_errs, rot_top_i.wb_assert_i.assert_errs);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// run length guard
	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d cycles", limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: verif/rot_tb_assert.sv
`timescale 1ns/1ps

module rot_wb_assert (
	input logic                 clk,
	input logic                 rst_n,
	input rot_bus_pkg::wb_req_t req_i,
	input rot_bus_pkg::wb_rsp_t rsp_i
);

	int assert_errs = 0; // failed assertion count

	// slave only answers a live strobe
	property ack_needs_strobe;
		@(posedge clk) disable iff (!rst_n) rsp_i.ack |-> (req_i.cyc && req_i.stb);
	endproperty

	property ack_single_pulse;
		@(posedge clk) disable iff (!rst_n) rsp_i.ack |=> !rsp_i.ack;
	endproperty

	property ack_low_in_reset;
		@(posedge clk) !rst_n |-> !rsp_i.ack;
	endproperty

	a_ack_strobe: assert property (ack_needs_strobe) else begin
		$error("ack without cyc and stb");
		assert_errs++;
	end

	a_ack_pulse: assert property (ack_single_pulse) else begin
		$error("ack held two cycles");
		assert_errs++;
	end

	a_ack_reset: assert property (ack_low_in_reset) else begin
		$error("ack high during reset");
		assert_errs++;
	end

endmodule

bind rot_top rot_wb_assert wb_assert_i (
	.clk  (clk),
	.rst_n(rst_n),
	.req_i(wb_i),
	.rsp_i(wb_o)
);

// File: verilog.f
logic/rot_bus_pkg.sv
logic/rot_cmd_pkg.sv
logic/rot_prng_lane.sv
logic/rot_regfile.sv
logic/rot_ctrl.sv
logic/rot_top.sv
verif/rot_tb_assert.sv
verif/rot_tb.sv
